// File: Makefile
# Verilator flow for the texture mip stage

VERILATOR ?= verilator
TB_TOP    ?= TextureMipStageTb
RTL_TOP   ?= TextureMipStage
FILELIST  ?= TextureMipStage.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing

RTL_SRCS := $(shell grep '^source/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: TextureMipStage.f
source/TexFixedPkg.sv
source/TmuCtrlPkg.sv
source/TmuConfigRegs.sv
source/LodCalculator.sv
source/TexelAddressUnit.sv
source/TexelRequestSerializer.sv
source/TextureMipStage.sv
verif/ClockGen.sv
verif/TextureMipStageTb.sv

// File: source/LodCalculator.sv
`timescale 1ns/1ps
// Mip level estimate from a texel and its diagonal screen-space neighbour
// One cycle latency, level 0 whenever mipmapping is off
module LodCalculator
(
    input  logic                                    aclk,
    input  logic                                    rstN,

    input  logic                                    mipEnable,
    input  logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogW,
    input  logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogH,

    // Pixel and its neighbour at x+1, y+1
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelS,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelT,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelSxy,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelTxy,

    output logic [TexFixedPkg::LodWidth-1:0]        lod
);
    import TexFixedPkg::*;

    logic [CoordWidth-1:0]      diffS;
    logic [CoordWidth-1:0]      diffT;
    logic [CoordFracBits-1:0]   magS;
    logic [CoordFracBits-1:0]   magT;
    logic [SizeLogWidth-1:0]    shiftU;
    logic [SizeLogWidth-1:0]    shiftV;
    logic [MaxSizeLog-1:0]      stepU;
    logic [MaxSizeLog-1:0]      stepV;
    logic [MaxSizeLog-1:0]      stepAny;

    // Index of the highest set bit plus one, zero for an empty mask
    function automatic logic [LodWidth-1:0] highestBitLevel(input logic [MaxSizeLog-1:0] mask);
        logic [LodWidth-1:0] level;
        level = '0;
        for (int i = 0; i < MaxSizeLog; i++)
        begin
            if (mask[i])
            begin
                level = LodWidth'(i + 1);
            end
        end
        return level;
    endfunction

    // Screen-space step per axis
    assign diffS = texelS - texelSxy;
    assign diffT = texelT - texelTxy;

    // Magnitude of the fractional part only
    assign magS = diffS[CoordWidth-1] ? (~diffS[CoordFracBits-1:0] + 1'b1)
                                      : diffS[CoordFracBits-1:0];
    assign magT = diffT[CoordWidth-1] ? (~diffT[CoordFracBits-1:0] + 1'b1)
                                      : diffT[CoordFracBits-1:0];

    // Top fraction bits scaled to texels of the base level
    assign shiftU = SizeLogWidth'(MaxSizeLog) - sizeLogW;
    assign shiftV = SizeLogWidth'(MaxSizeLog) - sizeLogH;
    assign stepU  = magS[CoordFracBits-1 -: MaxSizeLog] >> shiftU;
    assign stepV  = magT[CoordFracBits-1 -: MaxSizeLog] >> shiftV;

    // OR keeps the highest bit of the larger axis
    assign stepAny = stepU | stepV;

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            lod <= '0;
        end
        else if (mipEnable)
        begin
            lod <= highestBitLevel(stepAny);
        end
        else
        begin
            lod <= '0;
        end
    end

endmodule

// File: source/TexFixedPkg.sv
// Texture data formats
// Fixed point coordinates, mip level and size widths, packed chain addressing
package TexFixedPkg;

    // S16.15 texture coordinate, 1.0 spans the whole texture
    localparam int CoordWidth = 32;
    localparam int CoordFracBits = 15;

    // log2 of a texture dimension, 0 to 8
    localparam int SizeLogWidth = 4;

    // Largest supported log2 dimension, 256 texels per axis
    localparam int MaxSizeLog = 8;

    // Mip level number, 0 to 8
    localparam int LodWidth = 4;

    // Texel index into a packed chain
    // 256x256 base plus all coarser levels stays below 2^17
    localparam int TexAddrWidth = 17;

endpackage

// File: source/TexelAddressUnit.sv
`timescale 1ns/1ps
// One texture unit, two stages
// Level estimate, then clamp, scale and wrap into a packed mip chain address
module TexelAddressUnit
(
    input  logic                                    aclk,
    input  logic                                    rstN,

    input  logic                                    pixelValid,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelS,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelT,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelSxy,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelTxy,

    // Unit configuration
    input  logic                                    enable,
    input  TmuCtrlPkg::FilterMode                   filter,
    input  logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogW,
    input  logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogH,
    input  logic [TexFixedPkg::LodWidth-1:0]        maxLevel,

    output logic                                    resultValid,
    output logic [TexFixedPkg::LodWidth-1:0]        resultLod,
    output logic [TexFixedPkg::TexAddrWidth-1:0]    resultAddr
);
    import TexFixedPkg::*;
    import TmuCtrlPkg::*;

    logic                       mipEnable;
    logic [LodWidth-1:0]        lod;
    logic                       validS1;
    logic [MaxSizeLog-1:0]      uS1;
    logic [MaxSizeLog-1:0]      vS1;
    logic [SizeLogWidth-1:0]    minSizeLog;
    logic [LodWidth-1:0]        levelLimit;
    logic [LodWidth-1:0]        lodClamped;
    logic [SizeLogWidth-1:0]    widthLog;
    logic [SizeLogWidth-1:0]    heightLog;
    logic [MaxSizeLog-1:0]      uLevel;
    logic [MaxSizeLog-1:0]      vLevel;
    logic [TexAddrWidth-1:0]    baseOffset;
    logic [TexAddrWidth-1:0]    texelAddr;

    // Texel count of all levels finer than the given one
    function automatic logic [TexAddrWidth-1:0] chainOffset(
        input logic [SizeLogWidth-1:0] logW,
        input logic [SizeLogWidth-1:0] logH,
        input logic [LodWidth-1:0]     level
    );
        logic [TexAddrWidth-1:0] sum;
        int levelW;
        int levelH;
        sum = '0;
        for (int k = 0; k < MaxSizeLog; k++)
        begin
            // Each axis halves per level and stops at one texel
            levelW = (int'(logW) > k) ? int'(logW) - k : 0;
            levelH = (int'(logH) > k) ? int'(logH) - k : 0;
            if (k < int'(level))
            begin
                sum = sum + (TexAddrWidth'(1) << (levelW + levelH));
            end
        end
        return sum;
    endfunction

    assign mipEnable = (filter == FilterMipmap);

    LodCalculator lodCalc (
        .aclk      (aclk),
        .rstN      (rstN),
        .mipEnable (mipEnable),
        .sizeLogW  (sizeLogW),
        .sizeLogH  (sizeLogH),
        .texelS    (texelS),
        .texelT    (texelT),
        .texelSxy  (texelSxy),
        .texelTxy  (texelTxy),
        .lod       (lod)
    );

    // Stage 1 alongside the level, fraction scaled to base level texels
    // Dropping the integer part wraps the coordinate (repeat)
    always_ff @(posedge aclk)
    begin
        uS1 <= texelS[CoordFracBits-1 -: MaxSizeLog] >> (SizeLogWidth'(MaxSizeLog) - sizeLogW);
        vS1 <= texelT[CoordFracBits-1 -: MaxSizeLog] >> (SizeLogWidth'(MaxSizeLog) - sizeLogH);
    end

    // Clamp to maxLevel and to the smaller axis
    assign minSizeLog = (sizeLogW < sizeLogH) ? sizeLogW : sizeLogH;
    assign levelLimit = (maxLevel < LodWidth'(minSizeLog)) ? maxLevel : LodWidth'(minSizeLog);
    assign lodClamped = (lod < levelLimit) ? lod : levelLimit;

    // Dimensions of the chosen level
    assign widthLog  = sizeLogW - SizeLogWidth'(lodClamped);
    assign heightLog = sizeLogH - SizeLogWidth'(lodClamped);

    // Down to the level grid, then wrap to its size
    assign uLevel = (uS1 >> lodClamped) & MaxSizeLog'((1 << widthLog) - 1);
    assign vLevel = (vS1 >> lodClamped) & MaxSizeLog'((1 << heightLog) - 1);

    assign baseOffset = chainOffset(sizeLogW, sizeLogH, lodClamped);
    assign texelAddr  = baseOffset + (TexAddrWidth'(vLevel) << widthLog) + TexAddrWidth'(uLevel);

    // Valid pipe, disabled units never report
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            validS1     <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            validS1     <= pixelValid & enable;
            resultValid <= validS1;
        end
    end

    // Stage 2 result
    always_ff @(posedge aclk)
    begin
        resultLod  <= lodClamped;
        resultAddr <= texelAddr;
    end

endmodule

// File: source/TexelRequestSerializer.sv
`timescale 1ns/1ps
// Turns per-unit results into texel read requests
// Lowest pending unit goes first, one request per cycle
module TexelRequestSerializer
#(
    parameter int NumTmu = 2
)
(
    input  logic                                    aclk,
    input  logic                                    rstN,

    input  logic [NumTmu-1:0]                       resultValid,
    input  logic [TexFixedPkg::LodWidth-1:0]        resultLod [NumTmu],
    input  logic [TexFixedPkg::TexAddrWidth-1:0]    resultAddr [NumTmu],

    output logic                                    reqValid,
    output logic [TmuCtrlPkg::TmuIndexWidth-1:0]    reqTmu,
    output logic [TexFixedPkg::LodWidth-1:0]        reqLod,
    output logic [TexFixedPkg::TexAddrWidth-1:0]    reqAddr
);
    import TexFixedPkg::*;
    import TmuCtrlPkg::*;

    logic [NumTmu-1:0]          pending;
    logic [NumTmu-1:0]          grant;
    logic [LodWidth-1:0]        lodHold [NumTmu];
    logic [TexAddrWidth-1:0]    addrHold [NumTmu];

    // Pick the lowest pending unit
    // Walking downwards lets the lowest index win
    always_comb
    begin
        grant   = '0;
        reqTmu  = '0;
        reqLod  = '0;
        reqAddr = '0;
        for (int i = NumTmu - 1; i >= 0; i--)
        begin
            if (pending[i])
            begin
                grant   = '0;
                grant[i] = 1'b1;
                reqTmu  = TmuIndexWidth'(i);
                reqLod  = lodHold[i];
                reqAddr = addrHold[i];
            end
        end
    end

    assign reqValid = |pending;

    // New pixel replaces the mask, its last old entry leaves this same cycle
    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            pending <= '0;
        end
        else if (|resultValid)
        begin
            pending <= resultValid;
        end
        else
        begin
            pending <= pending & ~grant;
        end
    end

    // All units of a pixel report on the same cycle
    always_ff @(posedge aclk)
    begin
        if (|resultValid)
        begin
            lodHold  <= resultLod;
            addrHold <= resultAddr;
        end
    end

endmodule

// File: source/TextureMipStage.sv
`timescale 1ns/1ps
// Texture level-of-detail and mip address stage
// Config registers, one address unit per TMU, request serializer
module TextureMipStage
#(
    parameter int NumTmu = 2
)
(
    input  logic                                    aclk,
    input  logic                                    rstN,

    // Configuration
    input  logic                                    confWrite,
    input  logic [TmuCtrlPkg::TmuIndexWidth-1:0]    confTmu,
    input  TmuCtrlPkg::ConfOpcode                   confOp,
    input  logic [TmuCtrlPkg::ConfDataWidth-1:0]    confData,

    // Pixel, spaced at least NumTmu cycles apart
    input  logic                                    pixelValid,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelS,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelT,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelSxy,
    input  logic [TexFixedPkg::CoordWidth-1:0]      texelTxy,

    // Texel read requests
    output logic                                    reqValid,
    output logic [TmuCtrlPkg::TmuIndexWidth-1:0]    reqTmu,
    output logic [TexFixedPkg::LodWidth-1:0]        reqLod,
    output logic [TexFixedPkg::TexAddrWidth-1:0]    reqAddr
);
    import TexFixedPkg::*;
    import TmuCtrlPkg::*;

    logic [SizeLogWidth-1:0]    sizeLogW [NumTmu];
    logic [SizeLogWidth-1:0]    sizeLogH [NumTmu];
    logic [LodWidth-1:0]        maxLevel [NumTmu];
    FilterMode                  filter [NumTmu];
    logic [NumTmu-1:0]          enable;
    logic [NumTmu-1:0]          resultValid;
    logic [LodWidth-1:0]        resultLod [NumTmu];
    logic [TexAddrWidth-1:0]    resultAddr [NumTmu];

    TmuConfigRegs #(
        .NumTmu (NumTmu)
    ) configRegs (
        .aclk      (aclk),
        .rstN      (rstN),
        .confWrite (confWrite),
        .confTmu   (confTmu),
        .confOp    (confOp),
        .confData  (confData),
        .sizeLogW  (sizeLogW),
        .sizeLogH  (sizeLogH),
        .maxLevel  (maxLevel),
        .filter    (filter),
        .enable    (enable)
    );

    // All units see the same pixel
    for (genvar i = 0; i < NumTmu; i++)
    begin : genTmu
        TexelAddressUnit addrUnit (
            .aclk        (aclk),
            .rstN        (rstN),
            .pixelValid  (pixelValid),
            .texelS      (texelS),
            .texelT      (texelT),
            .texelSxy    (texelSxy),
            .texelTxy    (texelTxy),
            .enable      (enable[i]),
            .filter      (filter[i]),
            .sizeLogW    (sizeLogW[i]),
            .sizeLogH    (sizeLogH[i]),
            .maxLevel    (maxLevel[i]),
            .resultValid (resultValid[i]),
            .resultLod   (resultLod[i]),
            .resultAddr  (resultAddr[i])
        );
    end

    TexelRequestSerializer #(
        .NumTmu (NumTmu)
    ) serializer (
        .aclk        (aclk),
        .rstN        (rstN),
        .resultValid (resultValid),
        .resultLod   (resultLod),
        .resultAddr  (resultAddr),
        .reqValid    (reqValid),
        .reqTmu      (reqTmu),
        .reqLod      (reqLod),
        .reqAddr     (reqAddr)
    );

endmodule

// File: source/TmuConfigRegs.sv
`timescale 1ns/1ps
// Per-unit texture configuration registers
// Written one field at a time by opcode strobes, held as levels for each unit
module TmuConfigRegs
#(
    parameter int NumTmu = 2
)
(
    input  logic                                    aclk,
    input  logic                                    rstN,

    // Configuration write strobe
    input  logic                                    confWrite,
    input  logic [TmuCtrlPkg::TmuIndexWidth-1:0]    confTmu,
    input  TmuCtrlPkg::ConfOpcode                   confOp,
    input  logic [TmuCtrlPkg::ConfDataWidth-1:0]    confData,

    // Per-unit fields
    output logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogW [NumTmu],
    output logic [TexFixedPkg::SizeLogWidth-1:0]    sizeLogH [NumTmu],
    output logic [TexFixedPkg::LodWidth-1:0]        maxLevel [NumTmu],
    output TmuCtrlPkg::FilterMode                   filter [NumTmu],
    output logic [NumTmu-1:0]                       enable
);
    import TexFixedPkg::*;
    import TmuCtrlPkg::*;

    // Clip a log2 value to the largest supported texture
    function automatic logic [SizeLogWidth-1:0] satLog(input logic [SizeLogWidth-1:0] value);
        return (value > SizeLogWidth'(MaxSizeLog)) ? SizeLogWidth'(MaxSizeLog) : value;
    endfunction

    always_ff @(posedge aclk)
    begin
        if (!rstN)
        begin
            // All units come up disabled, level 0 only
            for (int i = 0; i < NumTmu; i++)
            begin
                sizeLogW[i] <= '0;
                sizeLogH[i] <= '0;
                maxLevel[i] <= '0;
                filter[i]   <= FilterNearest;
            end
            enable <= '0;
        end
        else if (confWrite)
        begin
            // Only the addressed unit changes, indices past NumTmu hit nothing
            for (int i = 0; i < NumTmu; i++)
            begin
                if (int'(confTmu) == i)
                begin
                    case (confOp)
                        ConfSetSize:
                        begin
                            sizeLogW[i] <= satLog(confData[SizeLogWidth-1:0]);
                            sizeLogH[i] <= satLog(confData[2*SizeLogWidth-1 -: SizeLogWidth]);
                        end
                        ConfSetMaxLevel: maxLevel[i] <= satLog(confData[LodWidth-1:0]);
                        ConfSetFilter:   filter[i]   <= FilterMode'(confData[0]);
                        ConfSetEnable:   enable[i]   <= confData[0];
                        default:         enable[i]   <= enable[i];
                    endcase
                end
            end
        end
    end

endmodule

// File: source/TmuCtrlPkg.sv
// Texture unit control definitions
// Configuration opcodes, filter modes and control field widths
package TmuCtrlPkg;

    // Configuration data word and unit index widths
    localparam int ConfDataWidth = 16;
    localparam int TmuIndexWidth = 2;

    // Configuration opcodes
    // ConfSetSize packs log2 width in data[3:0] and log2 height in data[7:4]
    // ConfSetMaxLevel uses data[3:0], filter and enable use data[0]
    typedef enum logic [1:0] {
        ConfSetSize     = 2'd0,
        ConfSetMaxLevel = 2'd1,
        ConfSetFilter   = 2'd2,
        ConfSetEnable   = 2'd3
    } ConfOpcode;

    // Nearest stays on level 0, mipmap follows the computed level
    typedef enum logic {
        FilterNearest = 1'b0,
        FilterMipmap  = 1'b1
    } FilterMode;

endpackage

// File: verif/ClockGen.sv
`timescale 1ns/1ps
// Testbench clock and synchronous reset source
module ClockGen
#(
    parameter int PeriodNs    = 4,
    parameter int ResetCycles = 5
)
(
    output logic aclk,
    output logic rstN
);
    // Free running clock, starts low
    initial
    begin
        aclk = 1'b0;
        forever #(PeriodNs / 2) aclk = ~aclk;
    end

    // Reset released just after a rising edge
    initial
    begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge aclk);
        #1;
        rstN = 1'b1;
    end

endmodule

// File: verif/TextureMipStageTb.sv
`timescale 1ns/1ps
// Testbench for the texture mip stage
// Random pixels against a reference of the level, clamp and chain address rules
module TextureMipStageTb;
    import TexFixedPkg::*;
    import TmuCtrlPkg::*;

    localparam int NumTmu = 2;
    localparam int PixelsPerTest = 24;
    localparam int NumTests = 6;
    localparam int PixelSpacing = NumTmu + 1;
    localparam int DrainLimitCycles = 2 * NumTmu + 8;
    // Every test fits its pixels plus config writes and drain in the margin
    localparam int WatchdogCycles = NumTests * (PixelsPerTest * PixelSpacing + 64) + 100;

    logic                       aclk;
    logic                       rstN;
    logic                       confWrite;
    logic [TmuIndexWidth-1:0]   confTmu;
    ConfOpcode                  confOp;
    logic [ConfDataWidth-1:0]   confData;
    logic                       pixelValid;
    logic [CoordWidth-1:0]      texelS;
    logic [CoordWidth-1:0]      texelT;
    logic [CoordWidth-1:0]      texelSxy;
    logic [CoordWidth-1:0]      texelTxy;
    logic                       reqValid;
    logic [TmuIndexWidth-1:0]   reqTmu;
    logic [LodWidth-1:0]        reqLod;
    logic [TexAddrWidth-1:0]    reqAddr;

    // Shadow of the unit configuration
    int     cfgW [NumTmu];
    int     cfgH [NumTmu];
    int     cfgMax [NumTmu];
    logic   cfgMip [NumTmu];
    logic   cfgEn [NumTmu];

    // Expected requests in arrival order
    int     expTmu [$];
    int     expLod [$];
    int     expAddr [$];
    int     expCycle [$];

    logic [31:0] rngState = 32'hf96f_53e4;
    int     cycleCount = 0;
    int     errorCount = 0;
    int     pixelsSent = 0;
    int     requestsSeen = 0;
    int     testIndex = 1;
    int     testsFailed = 0;
    int     errorsAtStart = 0;
    int     pixelsAtStart = 0;
    int     requestsAtStart = 0;

    ClockGen #(.PeriodNs(4), .ResetCycles(5)) clockGen (.aclk(aclk), .rstN(rstN));

    TextureMipStage #(.NumTmu(NumTmu)) DUT (
        .aclk(aclk), .rstN(rstN),
        .confWrite(confWrite), .confTmu(confTmu), .confOp(confOp), .confData(confData),
        .pixelValid(pixelValid), .texelS(texelS), .texelT(texelT),
        .texelSxy(texelSxy), .texelTxy(texelTxy),
        .reqValid(reqValid), .reqTmu(reqTmu), .reqLod(reqLod), .reqAddr(reqAddr)
    );

    // LCG with the numerical recipes constants
    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int limitToMax(input int value);
        return (value > MaxSizeLog) ? MaxSizeLog : value;
    endfunction

    function automatic void updateShadow(input int tmu, input ConfOpcode op,
                                         input logic [15:0] data);
        // Index past the last unit changes nothing
        if (tmu < NumTmu)
        begin
            case (op)
                ConfSetSize:
                begin
                    cfgW[tmu] = limitToMax(int'(data[3:0]));
                    cfgH[tmu] = limitToMax(int'(data[7:4]));
                end
                ConfSetMaxLevel: cfgMax[tmu] = limitToMax(int'(data[3:0]));
                ConfSetFilter:   cfgMip[tmu] = data[0];
                default:         cfgEn[tmu] = data[0];
            endcase
        end
    endfunction

    // Base level texels covered by one screen step on one axis
    function automatic int axisStep(input logic [31:0] coord, input logic [31:0] neighbour,
                                    input int sizeLog);
        logic [31:0] diff;
        int mag;
        diff = coord - neighbour;
        if (diff[31])
        begin
            mag = int'((32'd0 - diff) & 32'h7fff);
        end
        else
        begin
            mag = int'(diff & 32'h7fff);
        end
        return (mag >> 7) >> (MaxSizeLog - sizeLog);
    endfunction

    // Number of bits needed to hold the step
    function automatic int levelOfStep(input int step);
        int level;
        int rest;
        level = 0;
        rest = step;
        while (rest != 0)
        begin
            rest = rest >> 1;
            level++;
        end
        return level;
    endfunction

    // Fraction times texture size reduced to the level and wrapped to its size
    function automatic int levelCoord(input logic [31:0] coord, input int sizeLog, input int lod);
        int base;
        base = (int'(coord & 32'h7fff) << sizeLog) >> CoordFracBits;
        return (base >> lod) % (1 << (sizeLog - lod));
    endfunction

    // Texels in all levels finer than lod
    function automatic int packedBase(input int sizeW, input int sizeH, input int lod);
        int sum;
        int w;
        int h;
        sum = 0;
        for (int k = 0; k < lod; k++)
        begin
            w = (1 << sizeW) >> k;
            h = (1 << sizeH) >> k;
            sum += ((w < 1) ? 1 : w) * ((h < 1) ? 1 : h);
        end
        return sum;
    endfunction

    function automatic void expectPixel(input logic [31:0] s, input logic [31:0] t,
                                        input logic [31:0] sxy, input logic [31:0] txy,
                                        input int pixelCycle);
        int slot;
        int lod;
        int limit;
        int u;
        int v;
        slot = 0;
        for (int i = 0; i < NumTmu; i++)
        begin
            if (cfgEn[i])
            begin
                lod = 0;
                if (cfgMip[i])
                begin
                    lod = levelOfStep(axisStep(s, sxy, cfgW[i]) | axisStep(t, txy, cfgH[i]));
                end
                limit = cfgMax[i];
                limit = (cfgW[i] < limit) ? cfgW[i] : limit;
                limit = (cfgH[i] < limit) ? cfgH[i] : limit;
                lod = (lod > limit) ? limit : lod;
                u = levelCoord(s, cfgW[i], lod);
                v = levelCoord(t, cfgH[i], lod);
                expTmu.push_back(i);
                expLod.push_back(lod);
                expAddr.push_back(packedBase(cfgW[i], cfgH[i], lod)
                                  + v * (1 << (cfgW[i] - lod)) + u);
                // First request 3 cycles after the pixel and then one per cycle
                expCycle.push_back(pixelCycle + 3 + slot);
                slot++;
            end
        end
    endfunction

    task automatic writeConfig(input int tmu, input ConfOpcode op, input logic [15:0] data);
        @(posedge aclk);
        #1;
        confWrite = 1'b1;
        confTmu = TmuIndexWidth'(tmu);
        confOp = op;
        confData = data;
        updateShadow(tmu, op, data);
        @(posedge aclk);
        #1;
        confWrite = 1'b0;
    endtask

    // One random pixel
    // shiftMask limits how small the neighbour step gets
    task automatic sendPixel(input int spacing, input logic [3:0] shiftMask);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] sxy;
        logic [31:0] txy;
        s = nextRandom();
        t = nextRandom();
        r = nextRandom();
        sxy = r[12] ? s - ({17'd0, r[27:13]} >> (r[31:28] & shiftMask))
                    : s + ({17'd0, r[27:13]} >> (r[31:28] & shiftMask));
        r = nextRandom();
        txy = r[12] ? t - ({17'd0, r[27:13]} >> (r[31:28] & shiftMask))
                    : t + ({17'd0, r[27:13]} >> (r[31:28] & shiftMask));
        @(posedge aclk);
        #1;
        pixelValid = 1'b1;
        texelS = s;
        texelT = t;
        texelSxy = sxy;
        texelTxy = txy;
        expectPixel(s, t, sxy, txy, cycleCount);
        pixelsSent++;
        @(posedge aclk);
        #1;
        pixelValid = 1'b0;
        repeat (spacing - 2) @(posedge aclk);
    endtask

    task automatic finishTest(input string name);
        int waited;
        int errs;
        waited = 0;
        while (expTmu.size() > 0 && waited < DrainLimitCycles)
        begin
            @(posedge aclk);
            waited++;
        end
        if (expTmu.size() > 0)
        begin
            $display("Test %0d: %0d expected requests never came out", testIndex, expTmu.size());
            errorCount++;
            expTmu.delete();
            expLod.delete();
            expAddr.delete();
            expCycle.delete();
        end
        // Quiet window catches stray requests
        repeat (NumTmu + 4) @(posedge aclk);
        errs = errorCount - errorsAtStart;
        $display("Test %0d %s: %0d pixels, %0d requests, %0d errors", testIndex, name,
                 pixelsSent - pixelsAtStart, requestsSeen - requestsAtStart, errs);
        if (errs != 0)
        begin
            testsFailed++;
        end
        testIndex++;
        errorsAtStart = errorCount;
        pixelsAtStart = pixelsSent;
        requestsAtStart = requestsSeen;
    endtask

    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
    end

    // Requests are compared mid-cycle away from the edges
    always @(negedge aclk)
    begin
        if (reqValid === 1'b1)
        begin
            requestsSeen++;
            if (expTmu.size() == 0)
            begin
                $display("Unexpected request from TMU %0d at cycle %0d", reqTmu, cycleCount);
                errorCount++;
            end
            else
            begin
                if (cycleCount != expCycle[0])
                begin
                    $display("Request came at cycle %0d instead of cycle %0d",
                             cycleCount, expCycle[0]);
                    errorCount++;
                end
                if (reqTmu !== TmuIndexWidth'(expTmu[0]))
                begin
                    $display("** Error: reqTmu = 0x%0h, expected 0x%0h",
                             reqTmu, TmuIndexWidth'(expTmu[0]));
                    errorCount++;
                end
                if (reqLod !== LodWidth'(expLod[0]))
                begin
                    $display("** Error: reqLod = 0x%0h, expected 0x%0h",
                             reqLod, LodWidth'(expLod[0]));
                    errorCount++;
                end
                if (reqAddr !== TexAddrWidth'(expAddr[0]))
                begin
                    $display("** Error: reqAddr = 0x%0h, expected 0x%0h",
                             reqAddr, TexAddrWidth'(expAddr[0]));
                    errorCount++;
                end
                void'(expTmu.pop_front());
                void'(expLod.pop_front());
                void'(expAddr.pop_front());
                void'(expCycle.pop_front());
            end
        end
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge aclk);
        $display("Timeout after %0d cycles, the run did not finish", WatchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        confWrite = 1'b0;
        confTmu = '0;
        confOp = ConfSetSize;
        confData = '0;
        pixelValid = 1'b0;
        texelS = '0;
        texelT = '0;
        texelSxy = '0;
        texelTxy = '0;
        // Shadow starts at the reset values
        for (int i = 0; i < NumTmu; i++)
        begin
            cfgW[i] = 0;
            cfgH[i] = 0;
            cfgMax[i] = 0;
            cfgMip[i] = 1'b0;
            cfgEn[i] = 1'b0;
        end
        wait (rstN === 1'b1);
        @(posedge aclk);

        repeat (PixelsPerTest) sendPixel(PixelSpacing, 4'hf);
        finishTest("disabled after reset");

        // Nearest filter with sizes that may exceed 8 and get saturated
        // A high maxLevel leaves the filter alone to hold the level at 0
        for (int i = 0; i < NumTmu; i++)
        begin
            r = nextRandom();
            writeConfig(i, ConfSetSize, {8'd0, r[31:24]});
            writeConfig(i, ConfSetMaxLevel, 16'd8);
            writeConfig(i, ConfSetEnable, 16'd1);
        end
        repeat (PixelsPerTest) sendPixel(PixelSpacing, 4'hf);
        finishTest("nearest filter");

        for (int i = 0; i < NumTmu; i++)
        begin
            r = nextRandom();
            writeConfig(i, ConfSetFilter, 16'd1);
            writeConfig(i, ConfSetMaxLevel, 16'd8);
            writeConfig(i, ConfSetSize, (i == 0) ? 16'h0088 : {8'd0, r[31:24]});
        end
        repeat (PixelsPerTest) sendPixel(PixelSpacing, 4'hf);
        finishTest("mipmap levels");

        // Unit 0 limited by maxLevel and unit 1 by its 8 texel height
        r = nextRandom();
        writeConfig(0, ConfSetSize, 16'h0088);
        writeConfig(0, ConfSetMaxLevel, {14'd0, r[31:30]});
        writeConfig(1, ConfSetSize, 16'h0038);
        repeat (PixelsPerTest) sendPixel(PixelSpacing, 4'h3);
        finishTest("level clamp");

        writeConfig(0, ConfSetEnable, 16'd0);
        writeConfig(3, ConfSetEnable, 16'd1);
        repeat (PixelsPerTest) sendPixel(PixelSpacing, 4'hf);
        finishTest("one unit disabled");

        writeConfig(0, ConfSetEnable, 16'd1);
        repeat (PixelsPerTest) sendPixel(NumTmu, 4'hf);
        finishTest("back-to-back pixels");

        $display("Tests: %0d run, %0d failed, %0d errors, %0d requests",
                 testIndex - 1, testsFailed, errorCount, requestsSeen);
        if (errorCount == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
